/* logic/gpio_pkg.sv */
package gpio_pkg;

    // bus side widths.
    typedef logic [31:0] bus_word_t;
    typedef logic [7:0]  reg_offset_t;

    // pwm period and duty values.
    typedef logic [15:0] pwm_word_t;

    typedef struct packed {
        logic      read;
        logic      write;
        logic [31:0] address;
        bus_word_t write_data;
    } bus_req_t;

    // one channel's configuration.
    typedef struct packed {
        pwm_word_t period;
        pwm_word_t duty;
    } pwm_cfg_t;

    // register map, taken from the low address byte.
    localparam reg_offset_t reg_direction  = 8'h00;
    localparam reg_offset_t reg_value      = 8'h04;
    localparam reg_offset_t reg_pwm_enable = 8'h08;
    localparam reg_offset_t reg_pwm_period = 8'h0C;
    localparam reg_offset_t reg_pwm_duty   = 8'h10;
    localparam reg_offset_t reg_pin_input  = 8'h14;

    localparam int pwm_channels = 2;

    // write data bit that picks the channel on period and duty writes.
    localparam int pwm_select_bit = 16;

endpackage

/* logic/gpio_regs.sv */
`timescale 1ns/1ps

module gpio_regs #(
    parameter int pin_count = 20
) (
    input  logic                                              clk,
    input  logic                                              reset,
    input  gpio_pkg::bus_req_t                                bus_req,
    input  logic [pin_count-1:0]                              sync_in,
    output gpio_pkg::bus_word_t                               read_data,
    output logic                                              response,
    output logic [pin_count-1:0]                              direction,
    output logic [pin_count-1:0]                              value,
    output logic [gpio_pkg::pwm_channels-1:0]                 pwm_enable,
    output gpio_pkg::pwm_cfg_t [gpio_pkg::pwm_channels-1:0]   pwm_cfg
);

    import gpio_pkg::*;

    reg_offset_t offset;
    logic        channel;
    pwm_word_t   write_word;

    assign offset     = bus_req.address[7:0];
    assign channel    = bus_req.write_data[pwm_select_bit];
    assign write_word = bus_req.write_data[$bits(pwm_word_t)-1:0];

    // every request completes in its own cycle.
    assign response = bus_req.read | bus_req.write;

    always_ff @(posedge clk) begin
        if (reset) begin
            direction  <= '0;
            value      <= '0;
            pwm_enable <= '0;
            pwm_cfg    <= '0;
        end else if (bus_req.write) begin
            case (offset)
                reg_direction: begin
                    direction <= bus_req.write_data[pin_count-1:0];
                end
                reg_value: begin
                    value <= bus_req.write_data[pin_count-1:0];
                end
                reg_pwm_enable: begin
                    pwm_enable <= bus_req.write_data[pwm_channels-1:0];
                end
                reg_pwm_period: begin
                    pwm_cfg[channel].period <= write_word;
                end
                reg_pwm_duty: begin
                    pwm_cfg[channel].duty <= write_word;
                end
                // pin input is read only, the rest is unmapped.
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        read_data = '0;
        if (bus_req.read) begin
            case (offset)
                reg_direction: begin
                    read_data = bus_word_t'(direction);
                end
                reg_value: begin
                    read_data = bus_word_t'(value);
                end
                reg_pwm_enable: begin
                    read_data = bus_word_t'(pwm_enable);
                end
                // channel 1 in the upper half, channel 0 in the lower half.
                reg_pwm_period: begin
                    read_data = {pwm_cfg[1].period, pwm_cfg[0].period};
                end
                reg_pwm_duty: begin
                    read_data = {pwm_cfg[1].duty, pwm_cfg[0].duty};
                end
                reg_pin_input: begin
                    read_data = bus_word_t'(sync_in);
                end
                default: begin
                    read_data = '0;
                end
            endcase
        end
    end

    // the master issues at most one strobe per cycle.
    a_one_strobe: assert property (
        @(posedge clk) disable iff (reset)
        !(bus_req.read && bus_req.write)
    );

endmodule

/* logic/pwm_gen.sv */
`timescale 1ns/1ps

module pwm_gen (
    input  logic               clk,
    input  logic               reset,
    input  gpio_pkg::pwm_cfg_t cfg,
    output logic               pwm
);

    import gpio_pkg::*;

    pwm_word_t count;
    pwm_cfg_t  last_cfg;
    logic      cfg_changed;
    logic      wrap;

    assign cfg_changed = (cfg != last_cfg);

    // last count of the period, or a zero period that holds the counter.
    assign wrap = (cfg.period == '0) || (count >= cfg.period - pwm_word_t'(1));

    always_ff @(posedge clk) begin
        if (reset) begin
            count    <= '0;
            last_cfg <= '0;
            pwm      <= 1'b0;
        end else begin
            last_cfg <= cfg;
            if (cfg_changed || wrap) begin
                count <= '0;
            end else begin
                count <= count + pwm_word_t'(1);
            end
            // duty at or above the period keeps the output high.
            pwm <= (cfg.period != '0) && (count < cfg.duty);
        end
    end

    // a new configuration may leave a stale count for one cycle.
    a_count_in_period: assert property (
        @(posedge clk) disable iff (reset)
        (cfg.period != '0 && !cfg_changed) |-> (count < cfg.period)
    );

endmodule

/* logic/gpio_pad_mux.sv */
`timescale 1ns/1ps

module gpio_pad_mux #(
    parameter int pin_count = 20
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [pin_count-1:0]              direction,
    input  logic [pin_count-1:0]              value,
    input  logic [gpio_pkg::pwm_channels-1:0] pwm_enable,
    input  logic [gpio_pkg::pwm_channels-1:0] pwm,
    input  logic [pin_count-1:0]              pad_in,
    output logic [pin_count-1:0]              pad_out,
    output logic [pin_count-1:0]              pad_oe,
    output logic [pin_count-1:0]              sync_in
);

    import gpio_pkg::*;

    logic [pin_count-1:0] pwm_mask;
    logic [pin_count-1:0] pwm_bits;
    logic [pin_count-1:0] sync_meta;

    // only the low pins can be handed to a pwm channel.
    always_comb begin
        pwm_mask = '0;
        pwm_bits = '0;
        pwm_mask[pwm_channels-1:0] = pwm_enable;
        pwm_bits[pwm_channels-1:0] = pwm;
    end

    assign pad_oe  = direction | pwm_mask;
    assign pad_out = (value & direction & ~pwm_mask) | (pwm_bits & pwm_mask);

    // two stage synchronizer for the asynchronous pad inputs.
    always_ff @(posedge clk) begin
        if (reset) begin
            sync_meta <= '0;
            sync_in   <= '0;
        end else begin
            sync_meta <= pad_in;
            sync_in   <= sync_meta;
        end
    end

    // a pad that is not driven carries no data.
    a_out_needs_oe: assert property (
        @(posedge clk) disable iff (reset)
        (pad_out & ~pad_oe) == '0
    );

endmodule

/* logic/gpio_top.sv */
`timescale 1ns/1ps

module gpio_top #(
    parameter int pin_count = 20
) (
    input  logic                 clk,
    input  logic                 reset,
    input  gpio_pkg::bus_req_t   bus_req,
    input  logic [pin_count-1:0] pad_in,
    output gpio_pkg::bus_word_t  read_data,
    output logic                 response,
    output logic [pin_count-1:0] pad_out,
    output logic [pin_count-1:0] pad_oe
);

    import gpio_pkg::*;

    logic [pin_count-1:0]                direction;
    logic [pin_count-1:0]                value;
    logic [pin_count-1:0]                sync_in;
    logic [pwm_channels-1:0]             pwm_enable;
    logic [pwm_channels-1:0]             pwm_out;
    pwm_cfg_t [pwm_channels-1:0]         pwm_cfg;

    gpio_regs #(
        .pin_count(pin_count)
    ) regs0 (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .sync_in   (sync_in),
        .read_data (read_data),
        .response  (response),
        .direction (direction),
        .value     (value),
        .pwm_enable(pwm_enable),
        .pwm_cfg   (pwm_cfg)
    );

    pwm_gen pwm0 (
        .clk  (clk),
        .reset(reset),
        .cfg  (pwm_cfg[0]),
        .pwm  (pwm_out[0])
    );

    pwm_gen pwm1 (
        .clk  (clk),
        .reset(reset),
        .cfg  (pwm_cfg[1]),
        .pwm  (pwm_out[1])
    );

    gpio_pad_mux #(
        .pin_count(pin_count)
    ) pad_mux0 (
        .clk       (clk),
        .reset     (reset),
        .direction (direction),
        .value     (value),
        .pwm_enable(pwm_enable),
        .pwm       (pwm_out),
        .pad_in    (pad_in),
        .pad_out   (pad_out),
        .pad_oe    (pad_oe),
        .sync_in   (sync_in)
    );

endmodule

/* tests/gpio_tb.sv */
`timescale 1ns/1ps

module gpio_tb;

    import gpio_pkg::*;

    localparam int pins = 20;
    localparam int poll_limit = 10;
    localparam int watchdog_cycles = 5000;
    localparam bus_word_t pin_mask = {{(32 - pins){1'b0}}, {pins{1'b1}}};
    localparam reg_offset_t rw_offsets [5] = '{reg_direction, reg_value, reg_pwm_enable,
                                               reg_pwm_period, reg_pwm_duty};

    typedef logic [pins-1:0] pin_vec_t;

    logic      clk;
    logic      reset;
    bus_req_t  bus_req;
    pin_vec_t  pad_in;
    bus_word_t read_data;
    logic      response;
    pin_vec_t  pad_out;
    pin_vec_t  pad_oe;

    integer seed;
    int     errors;
    int     tests_run;

    gpio_top #(
        .pin_count(pins)
    ) dut0 (
        .clk      (clk),
        .reset    (reset),
        .bus_req  (bus_req),
        .pad_in   (pad_in),
        .read_data(read_data),
        .response (response),
        .pad_out  (pad_out),
        .pad_oe   (pad_oe)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_word(input string what, input bus_word_t got, input bus_word_t expected);
        if (got !== expected) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic check_pins(input string what, input pin_vec_t got, input pin_vec_t expected);
        if (got !== expected) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int got, input int expected);
        if (got != expected) begin
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic expected);
        if (got !== expected) begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, expected);
            errors++;
        end
    endtask

    // high cycles over a window of whole periods.
    function automatic int expected_high(input int period, input int duty, input int window);
        int high_per_period;
        if (period == 0) return 0;
        high_per_period = (duty < period) ? duty : period;
        return high_per_period * (window / period);
    endfunction

    function automatic bus_word_t pwm_data(input logic channel, input pwm_word_t v);
        return {15'h0, channel, v};
    endfunction

    task automatic bus_write(input reg_offset_t offset, input bus_word_t data);
        @(negedge clk);
        bus_req.write = 1'b1;
        bus_req.address = {24'h0, offset};
        bus_req.write_data = data;
        #1;
        check_flag("write response", response, 1'b1);
        @(negedge clk);
        bus_req = '0;
    endtask

    task automatic bus_read(input reg_offset_t offset, output bus_word_t data);
        @(negedge clk);
        bus_req.read = 1'b1;
        bus_req.address = {24'h0, offset};
        #1;
        data = read_data;
        check_flag("read response", response, 1'b1);
        @(negedge clk);
        bus_req = '0;
    endtask

    task automatic count_high(input int window, output int high0, output int high1);
        high0 = 0;
        high1 = 0;
        for (int i = 0; i < window; i++) begin
            @(negedge clk);
            if (pad_out[0]) high0++;
            if (pad_out[1]) high1++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic test_reset_state();
        int        start;
        bus_word_t word;
        start = errors;
        @(negedge clk);
        #1;
        check_flag("idle response", response, 1'b0);
        check_word("idle read_data", read_data, '0);
        check_pins("pad_out", pad_out, '0);
        check_pins("pad_oe", pad_oe, '0);
        foreach (rw_offsets[i]) begin
            bus_read(rw_offsets[i], word);
            check_word("register after reset", word, '0);
        end
        bus_read(reg_pin_input, word);
        check_word("pin input after reset", word, '0);
        finish_test("reset_state", start);
    endtask

    task automatic test_round_trip();
        int        start;
        bus_word_t dir;
        bus_word_t val;
        bus_word_t word;
        start = errors;
        dir = $random(seed);
        val = $random(seed);
        bus_write(reg_direction, dir);
        bus_write(reg_value, val);
        check_pins("pad_oe", pad_oe, dir[pins-1:0]);
        check_pins("pad_out", pad_out, val[pins-1:0] & dir[pins-1:0]);
        bus_read(reg_direction, word);
        check_word("direction", word, dir & pin_mask);
        bus_read(reg_value, word);
        check_word("value", word, val & pin_mask);
        finish_test("round_trip", start);
    endtask

    task automatic test_synchronizer();
        int        start;
        int        cycles;
        logic      matched;
        bus_word_t rand_word;
        bus_word_t word;
        pin_vec_t  old_in;
        start = errors;
        old_in = pad_in;
        rand_word = $random(seed);
        // the change and the read share one cycle.
        @(negedge clk);
        pad_in = rand_word[pins-1:0];
        bus_req.read = 1'b1;
        bus_req.address = {24'h0, reg_pin_input};
        #1;
        check_word("pin input in the change cycle", read_data, bus_word_t'(old_in));
        @(negedge clk);
        bus_req = '0;
        matched = 1'b0;
        cycles = 0;
        while (!matched && cycles < poll_limit) begin
            bus_read(reg_pin_input, word);
            cycles += 2;
            if (word == bus_word_t'(pad_in)) matched = 1'b1;
        end
        if (!matched) begin
            $display("pin input never matched pad_in within %0d cycles", poll_limit);
            errors++;
        end
        finish_test("synchronizer", start);
    endtask

    task automatic test_pwm_waveform();
        int        start;
        int        high0;
        int        high1;
        bus_word_t word;
        start = errors;
        // no pin is an output until pwm takes pins 0 and 1.
        bus_write(reg_direction, '0);
        bus_write(reg_pwm_period, pwm_data(1'b0, 16'd10));
        bus_write(reg_pwm_period, pwm_data(1'b1, 16'd8));
        bus_write(reg_pwm_duty, pwm_data(1'b0, 16'd3));
        bus_write(reg_pwm_duty, pwm_data(1'b1, 16'd8));
        bus_write(reg_pwm_enable, 32'h3);
        check_pins("pwm pad_oe", pad_oe, pin_vec_t'(2'b11));
        count_high(40, high0, high1);
        check_count("channel 0 high cycles", high0, expected_high(10, 3, 40));
        check_count("channel 1 high cycles", high1, expected_high(8, 8, 40));
        bus_read(reg_pwm_period, word);
        check_word("pwm period", word, {16'd8, 16'd10});
        bus_read(reg_pwm_duty, word);
        check_word("pwm duty", word, {16'd8, 16'd3});
        finish_test("pwm_waveform", start);
    endtask

    task automatic test_pwm_edges();
        int        start;
        int        high0;
        int        high1;
        bus_word_t dir;
        bus_word_t val;
        start = errors;
        bus_write(reg_pwm_period, pwm_data(1'b0, 16'd0));
        count_high(20, high0, high1);
        check_count("zero period high cycles", high0, expected_high(0, 3, 20));
        dir = $random(seed);
        val = $random(seed);
        // pin 0 drives a one and pin 1 is an input, unlike either pwm channel.
        dir[1:0] = 2'b01;
        val[1:0] = 2'b01;
        bus_write(reg_direction, dir);
        bus_write(reg_value, val);
        bus_write(reg_pwm_enable, 32'h0);
        check_pins("pad_oe without pwm", pad_oe, dir[pins-1:0]);
        check_pins("pad_out without pwm", pad_out, val[pins-1:0] & dir[pins-1:0]);
        finish_test("pwm_edges", start);
    endtask

    task automatic test_unmapped();
        int        start;
        bus_word_t snap [5];
        bus_word_t word;
        start = errors;
        foreach (rw_offsets[i]) begin
            bus_read(rw_offsets[i], snap[i]);
        end
        bus_write(8'h20, $random(seed));
        bus_write(reg_pin_input, $random(seed));
        foreach (rw_offsets[i]) begin
            bus_read(rw_offsets[i], word);
            check_word("register after ignored write", word, snap[i]);
        end
        bus_read(8'h20, word);
        check_word("unmapped read 0x20", word, '0);
        bus_read(8'h18, word);
        check_word("unmapped read 0x18", word, '0);
        finish_test("unmapped", start);
    endtask

    initial begin
        seed = 32'h25146327;
        errors = 0;
        tests_run = 0;
        reset = 1'b1;
        bus_req = '0;
        pad_in = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_reset_state();
        test_round_trip();
        test_synchronizer();
        test_pwm_waveform();
        test_pwm_edges();
        test_unmapped();
        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("the tests did not finish within %0d cycles", watchdog_cycles);
        $display("Regression failed");
        $finish;
    end

endmodule

/* sim.f */
logic/gpio_pkg.sv
logic/gpio_regs.sv
logic/pwm_gen.sv
logic/gpio_pad_mux.sv
logic/gpio_top.sv
tests/gpio_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the gpio testbench with verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module gpio_tb \
    --Mdir obj_dir \
    -o gpio_tb_sim \
    -f sim.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/gpio_tb_sim)
sim_status=$?
echo "$sim_output"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "Regression passed"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
